//--- Makefile
# Verilator build and run of the mesh router testbench

VERILATOR ?= verilator
TOP       ?= tb_mesh_router
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: check

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; \
	elif ! grep -q "TESTBENCH PASSED" $(LOG); then echo "no result in $(LOG)"; exit 1; \
	else echo "simulation passed"; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/flit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module flit_fifo #(
   parameter int fifo_depth = 4
) (
   input  wire                  clk,
   input  wire                  arst_n,
   input  wire                  push,
   input  noc_flit_pkg::flit_t  din,
   input  wire                  pop,
   output noc_flit_pkg::flit_t  dout,
   output logic                 empty,
   output logic                 full
);
   import noc_flit_pkg::*;

   localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
   localparam int count_w = $clog2(fifo_depth + 1);

   // storage
   flit_t mem [fifo_depth];

   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [count_w-1:0] count;

   // pointer wrap at the last slot, depth need not be a power of two
   function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
      if (p == ptr_w'(fifo_depth - 1)) begin
         return '0;
      end
      return p + 1'b1;
   endfunction

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         // simultaneous push and pop keep the count
         case ({push, pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // write port
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= din;
      end
   end

   // head of queue, valid while not empty
   assign dout = mem[rd_ptr];
   assign empty = (count == '0);
   assign full = (count == count_w'(fifo_depth));

endmodule

`default_nettype wire

//--- hdl/input_unit.sv
`timescale 1ns/1ps
`default_nettype none

module input_unit #(
   parameter int x_cur = 0,
   parameter int y_cur = 0,
   parameter int fifo_depth = 4
) (
   input  wire                     clk,
   input  wire                     arst_n,
   input  wire                     in_valid,
   input  noc_flit_pkg::flit_t     in_flit,
   input  noc_port_pkg::port_req_t grant,
   output noc_port_pkg::port_req_t req,
   output noc_flit_pkg::flit_t     head_flit,
   output logic                    pop
);
   import noc_flit_pkg::*;
   import noc_port_pkg::*;

   // wormhole state of this input
   typedef enum logic {
      IDLE,
      ROUTED
   } wh_state_t;

   wh_state_t state_q;
   port_req_t route_q;
   port_req_t rc_req;
   port_req_t route;
   flit_t fifo_head;
   logic fifo_empty;
   logic head_is_tail;

   // flits land here on the edge they are strobed
   flit_fifo #(
      .fifo_depth(fifo_depth)
   ) u_fifo (
      .clk   (clk),
      .arst_n(arst_n),
      .push  (in_valid),
      .din   (in_flit),
      .pop   (pop),
      .dout  (fifo_head),
      .empty (fifo_empty),
      .full  ()
   );

   // only looked at while idle, when the queue head is a head flit
   route_compute #(
      .x_cur(x_cur),
      .y_cur(y_cur)
   ) u_route (
      .dest_x(fifo_head.dest_x),
      .dest_y(fifo_head.dest_y),
      .port  (),
      .req   (rc_req)
   );

   assign head_is_tail = is_tail(fifo_head.kind);

   // body and tail flits follow the latched route
   assign route = (state_q == ROUTED) ? route_q : rc_req;
   assign req = fifo_empty ? '0 : route;

   // output unit grants only on a raised request
   assign pop = |grant;
   assign head_flit = fifo_head;

   ////////////////////////////////////////////////////////////////////////////
   // packet tracking
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= IDLE;
      end else begin
         case (state_q)
            IDLE: if (pop && !head_is_tail) state_q <= ROUTED;
            ROUTED: if (pop && head_is_tail) state_q <= IDLE;
            default: state_q <= IDLE;
         endcase
      end
   end

   // hold the head's route for the rest of the packet
   always_ff @(posedge clk) begin
      if (state_q == IDLE && pop) begin
         route_q <= rc_req;
      end
   end

endmodule

`default_nettype wire

//--- hdl/mesh_router.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_router #(
   parameter int x_cur = 2,
   parameter int y_cur = 3,
   parameter int fifo_depth = 4
) (
   input  wire                                                 clk,
   input  wire                                                 arst_n,
   input  noc_port_pkg::port_req_t                             in_valid,
   input  noc_flit_pkg::flit_t [noc_port_pkg::num_ports-1:0]   in_flit,
   output noc_port_pkg::port_req_t                             out_valid,
   output noc_flit_pkg::flit_t [noc_port_pkg::num_ports-1:0]   out_flit
);
   import noc_flit_pkg::*;
   import noc_port_pkg::*;

   // row per input unit
   port_req_t [num_ports-1:0] in_req;
   port_req_t [num_ports-1:0] in_grant;
   // row per output unit
   port_req_t [num_ports-1:0] out_req;
   port_req_t [num_ports-1:0] out_grant;

   // queue heads, broadcast to all outputs
   flit_t [num_ports-1:0] head_flits;
   // one pop strobe per input
   port_req_t in_pop;

   ////////////////////////////////////////////////////////////////////////////
   // input side
   ////////////////////////////////////////////////////////////////////////////
   for (genvar i = 0; i < num_ports; i++) begin : g_in
      input_unit #(
         .x_cur     (x_cur),
         .y_cur     (y_cur),
         .fifo_depth(fifo_depth)
      ) u_in (
         .clk      (clk),
         .arst_n   (arst_n),
         .in_valid (in_valid[i]),
         .in_flit  (in_flit[i]),
         .grant    (in_grant[i]),
         .req      (in_req[i]),
         .head_flit(head_flits[i]),
         .pop      (in_pop[i])
      );
   end

   // request matrix by input, grant matrix by output
   always_comb begin
      for (int o = 0; o < num_ports; o++) begin
         for (int i = 0; i < num_ports; i++) begin
            out_req[o][i] = in_req[i][o];
            in_grant[i][o] = out_grant[o][i];
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // output side
   ////////////////////////////////////////////////////////////////////////////
   for (genvar o = 0; o < num_ports; o++) begin : g_out
      output_unit u_out (
         .clk      (clk),
         .arst_n   (arst_n),
         .req      (out_req[o]),
         .flits    (head_flits),
         .grant    (out_grant[o]),
         .out_valid(out_valid[o]),
         .out_flit (out_flit[o])
      );
   end

endmodule

`default_nettype wire

//--- hdl/noc_flit_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// flit format shared by every router port
////////////////////////////////////////////////////////////////////////////
package noc_flit_pkg;

   // 4 x 4 mesh, two bits per axis
   localparam int coord_w = 2;
   localparam int payload_w = 16;

   typedef logic [coord_w-1:0] coord_t;
   typedef logic [payload_w-1:0] payload_t;

   // bit 1 marks a head, bit 0 marks a tail
   typedef logic [1:0] flit_kind_t;

   localparam flit_kind_t FLIT_BODY = 2'b00;
   localparam flit_kind_t FLIT_TAIL = 2'b01;
   localparam flit_kind_t FLIT_HEAD = 2'b10;
   localparam flit_kind_t FLIT_SINGLE = 2'b11;

   // dest fields only meaningful on head or single
   typedef struct packed {
      flit_kind_t kind;
      coord_t dest_x;
      coord_t dest_y;
      payload_t payload;
   } flit_t;

   // last flit of a packet
   function automatic logic is_tail(input flit_kind_t kind);
      return (kind == FLIT_TAIL) || (kind == FLIT_SINGLE);
   endfunction

endpackage

`default_nettype wire

//--- hdl/noc_port_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// router port numbering and request vectors
////////////////////////////////////////////////////////////////////////////
package noc_port_pkg;

   // local plus four mesh neighbours
   localparam int num_ports = 5;

   // port order fixes the bit order of every request and grant
   typedef enum logic [2:0] {
      PORT_LOCAL = 3'd0,
      PORT_EAST = 3'd1,
      PORT_NORTH = 3'd2,
      PORT_WEST = 3'd3,
      PORT_SOUTH = 3'd4
   } port_t;

   // one bit per port, indexed by port_t
   typedef logic [num_ports-1:0] port_req_t;

   // round-robin successor, south wraps to local
   function automatic port_t next_port(input port_t p);
      if (p == PORT_SOUTH) begin
         return PORT_LOCAL;
      end
      return port_t'(3'(p) + 3'd1);
   endfunction

endpackage

`default_nettype wire

//--- hdl/output_unit.sv
`timescale 1ns/1ps
`default_nettype none

module output_unit (
   input  wire                                                 clk,
   input  wire                                                 arst_n,
   input  noc_port_pkg::port_req_t                             req,
   input  noc_flit_pkg::flit_t [noc_port_pkg::num_ports-1:0]   flits,
   output noc_port_pkg::port_req_t                             grant,
   output logic                                                out_valid,
   output noc_flit_pkg::flit_t                                 out_flit
);
   import noc_flit_pkg::*;
   import noc_port_pkg::*;

   // priority pointer, owner of a packet in flight
   port_t ptr_q;
   port_t owner_q;
   logic locked_q;

   port_t winner;
   port_t cur_owner;
   logic any_req;
   logic fire;
   flit_t sel_flit;

   ////////////////////////////////////////////////////////////////////////////
   // round-robin search starting at the pointer
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      port_t idx;
      idx = ptr_q;
      winner = ptr_q;
      any_req = 1'b0;
      for (int i = 0; i < num_ports; i++) begin
         // first requester at or after the pointer wins
         if (!any_req && req[idx]) begin
            winner = idx;
            any_req = 1'b1;
         end
         idx = next_port(idx);
      end
   end

   // a locked output serves only its owner
   assign cur_owner = locked_q ? owner_q : winner;
   assign fire = locked_q ? req[owner_q] : any_req;
   assign grant = fire ? (port_req_t'(1'b1) << cur_owner) : '0;
   assign sel_flit = flits[cur_owner];

   ////////////////////////////////////////////////////////////////////////////
   // arbiter state
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ptr_q <= PORT_LOCAL;
         owner_q <= PORT_LOCAL;
         locked_q <= 1'b0;
      end else if (fire) begin
         owner_q <= cur_owner;
         // stay on this input until its tail goes out
         locked_q <= !is_tail(sel_flit.kind);
         // pointer moves once per packet, at its first flit
         if (!locked_q) begin
            ptr_q <= next_port(winner);
         end
      end
   end

   // output register
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= fire;
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         out_flit <= sel_flit;
      end
   end

endmodule

`default_nettype wire

//--- hdl/route_compute.sv
`timescale 1ns/1ps
`default_nettype none

module route_compute #(
   parameter int x_cur = 0,
   parameter int y_cur = 0
) (
   input  noc_flit_pkg::coord_t    dest_x,
   input  noc_flit_pkg::coord_t    dest_y,
   output noc_port_pkg::port_t     port,
   output noc_port_pkg::port_req_t req
);
   import noc_flit_pkg::*;
   import noc_port_pkg::*;

   // one extra bit so the difference keeps its sign
   localparam int diff_w = coord_w + 1;

   logic signed [diff_w-1:0] x_here;
   logic signed [diff_w-1:0] y_here;
   logic signed [diff_w-1:0] x_diff;
   logic signed [diff_w-1:0] y_diff;

   // own node position, zero extended
   assign x_here = $signed({1'b0, coord_t'(x_cur)});
   assign y_here = $signed({1'b0, coord_t'(y_cur)});

   assign x_diff = $signed({1'b0, dest_x}) - x_here;
   assign y_diff = $signed({1'b0, dest_y}) - y_here;

   ////////////////////////////////////////////////////////////////////////////
   // dimension order, x resolved before y
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      if (x_diff > 0) begin
         port = PORT_EAST;
      end else if (x_diff < 0) begin
         port = PORT_WEST;
      end else if (y_diff > 0) begin
         // y grows toward the south edge
         port = PORT_SOUTH;
      end else if (y_diff < 0) begin
         port = PORT_NORTH;
      end else begin
         // arrived
         port = PORT_LOCAL;
      end
   end

   // exactly one bit, at the chosen port
   assign req = port_req_t'(1'b1) << port;

endmodule

`default_nettype wire

//--- src.f
hdl/noc_flit_pkg.sv
hdl/noc_port_pkg.sv
hdl/route_compute.sv
hdl/flit_fifo.sv
hdl/input_unit.sv
hdl/output_unit.sv
hdl/mesh_router.sv
testbench/mesh_router_sva.sv
testbench/tb_mesh_router.sv

//--- testbench/mesh_router_sva.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_router_sva #(
   parameter int fifo_depth = 4
) (
   input  wire                                                    clk,
   input  wire                                                    arst_n,
   input  noc_port_pkg::port_req_t                                in_valid,
   input  noc_port_pkg::port_req_t                                in_pop,
   input  noc_port_pkg::port_req_t [noc_port_pkg::num_ports-1:0]  in_req,
   input  noc_port_pkg::port_req_t                                out_valid,
   input  noc_flit_pkg::flit_t [noc_port_pkg::num_ports-1:0]      out_flit
);
   import noc_flit_pkg::*;
   import noc_port_pkg::*;

   // shadow fifo occupancy from push and pop strobes
   int occ [num_ports];
   // output link is between head and tail
   port_req_t open_pkt;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         open_pkt <= '0;
         for (int i = 0; i < num_ports; i++) begin
            occ[i] <= 0;
         end
      end else begin
         for (int i = 0; i < num_ports; i++) begin
            occ[i] <= occ[i] + int'(in_valid[i]) - int'(in_pop[i]);
            if (out_valid[i]) begin
               open_pkt[i] <= (out_flit[i].kind == FLIT_HEAD) || (out_flit[i].kind == FLIT_BODY);
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // link quiet through reset and the cycle after
   ////////////////////////////////////////////////////////////////////////////
   a_idle_in_reset: assert property (@(posedge clk) !arst_n |-> out_valid == '0)
      else $error("out_valid active during reset");
   a_idle_after_reset: assert property (@(posedge clk) !arst_n |=> out_valid == '0)
      else $error("out_valid active in the cycle after reset");

   for (genvar p = 0; p < num_ports; p++) begin : g_port
      // no new head before the open packet's tail
      a_no_head_inside: assert property (@(posedge clk) disable iff (!arst_n)
         out_valid[p] && open_pkt[p] |->
            !((out_flit[p].kind == FLIT_HEAD) || (out_flit[p].kind == FLIT_SINGLE)))
         else $error("output %0d started a packet inside another", p);
      a_head_first: assert property (@(posedge clk) disable iff (!arst_n)
         out_valid[p] && !open_pkt[p] |->
            (out_flit[p].kind == FLIT_HEAD) || (out_flit[p].kind == FLIT_SINGLE))
         else $error("output %0d sent a body or tail flit with no packet open", p);
      // upstream keeps within the buffer while blocked
      a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
         in_valid[p] |-> occ[p] < fifo_depth)
         else $error("flit pushed into full fifo of input %0d", p);
      a_req_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(in_req[p]))
         else $error("input %0d requests more than one output", p);
   end

endmodule

bind mesh_router mesh_router_sva #(
   .fifo_depth(fifo_depth)
) u_sva (
   .clk      (clk),
   .arst_n   (arst_n),
   .in_valid (in_valid),
   .in_pop   (in_pop),
   .in_req   (in_req),
   .out_valid(out_valid),
   .out_flit (out_flit)
);

`default_nettype wire

//--- testbench/tb_mesh_router.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mesh_router;
   import noc_flit_pkg::*;
   import noc_port_pkg::*;

   localparam int node_x = 2;
   localparam int node_y = 3;
   // input edge to output edge, uncontended
   localparam int lat = 2;
   localparam int drain_limit = 200;

   // one expected flit, due cycle used only when latency is fixed
   typedef struct packed {
      flit_t flit;
      logic [31:0] due;
      logic check_lat;
   } exp_t;

   logic clk;
   logic arst_n;
   port_req_t in_valid;
   flit_t [num_ports-1:0] in_flit;
   port_req_t out_valid;
   flit_t [num_ports-1:0] out_flit;

   int seed;
   int cyc = 0;
   int errors;
   int checked;
   int seq;
   logic timed_out;
   logic traffic_started;
   logic lat_check;

   // expected flits, index output * num_ports + source
   exp_t exp_q [num_ports*num_ports][$];
   // sources of heads in arrival order, per output
   int head_src_q [num_ports][$];
   // round-robin pointer predicted from served heads
   int ptr_model [num_ports];
   // source of the open packet per output, -1 between packets
   int open_src [num_ports];
   // output of the packet in flight, per input
   int cur_out [num_ports];

   mesh_router #(
      .x_cur     (node_x),
      .y_cur     (node_y),
      .fifo_depth(4)
   ) UUT (
      .clk      (clk),
      .arst_n   (arst_n),
      .in_valid (in_valid),
      .in_flit  (in_flit),
      .out_valid(out_valid),
      .out_flit (out_flit)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////
   // x first, then y, y grows toward the south
   function automatic int xy_port(input int dx, input int dy);
      if (dx > node_x) return int'(PORT_EAST);
      if (dx < node_x) return int'(PORT_WEST);
      if (dy > node_y) return int'(PORT_SOUTH);
      if (dy < node_y) return int'(PORT_NORTH);
      return int'(PORT_LOCAL);
   endfunction

   // steps from the pointer to an input, round-robin order
   function automatic int rr_dist(input int from, input int to);
      return (to - from + num_ports) % num_ports;
   endfunction

   function automatic flit_kind_t kind_of(input int idx, input int len);
      if (len == 1) return FLIT_SINGLE;
      if (idx == 0) return FLIT_HEAD;
      if (idx == len - 1) return FLIT_TAIL;
      return FLIT_BODY;
   endfunction

   // payload carries source and sequence number
   function automatic flit_t make_flit(input flit_kind_t kind, input int dx, input int dy,
                                       input int src, input int n);
      flit_t f;
      f.kind = kind;
      if (kind == FLIT_HEAD || kind == FLIT_SINGLE) begin
         f.dest_x = coord_t'(dx);
         f.dest_y = coord_t'(dy);
      end else begin
         // mirrored destination, would route elsewhere if looked at
         f.dest_x = ~coord_t'(dx);
         f.dest_y = ~coord_t'(dy);
      end
      f.payload = {3'(src), 13'(n)};
      return f;
   endfunction

   function automatic int pending();
      int n;
      n = 0;
      for (int i = 0; i < num_ports * num_ports; i++) begin
         n += exp_q[i].size();
      end
      return n;
   endfunction

   // one clock of stimulus, each valid flit also enters the model
   task automatic drive_cycle(input port_req_t valid, input flit_t [num_ports-1:0] flits);
      exp_t e;
      int o;
      @(posedge clk);
      #2;
      in_valid = valid;
      in_flit = flits;
      for (int i = 0; i < num_ports; i++) begin
         if (valid[i]) begin
            traffic_started = 1'b1;
            // body and tail follow the route of their head
            if (flits[i].kind == FLIT_HEAD || flits[i].kind == FLIT_SINGLE) begin
               cur_out[i] = xy_port(int'(flits[i].dest_x), int'(flits[i].dest_y));
            end
            o = cur_out[i];
            e.flit = flits[i];
            e.due = 32'(cyc + lat);
            e.check_lat = lat_check;
            exp_q[o * num_ports + i].push_back(e);
         end
      end
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while (pending() != 0 && n < drain_limit) begin
         @(posedge clk);
         n++;
      end
      if (pending() != 0) begin
         $display("timeout at %0t: %0d expected flits never arrived", $time, pending());
         timed_out = 1'b1;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // scoreboard, sampled mid-cycle
   ////////////////////////////////////////////////////////////////////////////
   task automatic check_output(input int o);
      flit_t got;
      exp_t e;
      int src;
      logic known;
      logic is_head;
      got = out_flit[o];
      src = int'(got.payload[15:13]);
      checked++;
      known = 1'b0;
      if (src < num_ports) begin
         known = exp_q[o * num_ports + src].size() != 0;
      end
      assert (known) else begin
         errors++;
         $display("%0t: output %0d sent a flit nobody expects, payload %h",
                  $time, o, got.payload);
      end
      if (known) begin
         e = exp_q[o * num_ports + src].pop_front();
         assert (got == e.flit) else begin
            errors++;
            $display("Error at %0t: out_flit[%0d] expected %h, got %h", $time, o, e.flit, got);
         end
         if (e.check_lat) begin
            assert (cyc == int'(e.due)) else begin
               errors++;
               $display("Error at %0t: arrival cycle of out_flit[%0d] expected %0d, got %0d",
                        $time, o, e.due, cyc);
            end
         end
      end
      // framing, a packet must not be split by another input
      is_head = (got.kind == FLIT_HEAD) || (got.kind == FLIT_SINGLE);
      if (is_head) begin
         assert (open_src[o] < 0) else begin
            errors++;
            $display("%0t: output %0d began a packet before the previous tail", $time, o);
         end
         head_src_q[o].push_back(src);
         ptr_model[o] = (src + 1) % num_ports;
      end else begin
         assert (open_src[o] == src) else begin
            errors++;
            $display("%0t: output %0d mixed input %0d into a packet from input %0d",
                     $time, o, src, open_src[o]);
         end
      end
      open_src[o] = (got.kind == FLIT_HEAD || got.kind == FLIT_BODY) ? src : -1;
   endtask

   always @(negedge clk) begin
      if (arst_n) begin
         if (!traffic_started) begin
            assert (out_valid == '0) else begin
               errors++;
               $display("Error at %0t: out_valid expected %b, got %b", $time, 5'b0, out_valid);
            end
         end
         for (int o = 0; o < num_ports; o++) begin
            if (out_valid[o]) begin
               check_output(o);
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////////////////////
   // local input, every mesh destination once
   task automatic single_sweep();
      flit_t [num_ports-1:0] f;
      lat_check = 1'b1;
      for (int dx = 0; dx < 4; dx++) begin
         for (int dy = 0; dy < 4; dy++) begin
            f = '0;
            f[int'(PORT_LOCAL)] = make_flit(FLIT_SINGLE, dx, dy, int'(PORT_LOCAL), seq);
            seq++;
            drive_cycle(port_req_t'(5'b00001), f);
         end
      end
      drive_cycle('0, '0);
      wait_drained();
   endtask

   // west input, four flits toward (0,1)
   task automatic long_packet();
      flit_t [num_ports-1:0] f;
      lat_check = 1'b1;
      for (int c = 0; c < 4; c++) begin
         f = '0;
         f[int'(PORT_WEST)] = make_flit(kind_of(c, 4), 0, 1, int'(PORT_WEST), seq);
         seq++;
         drive_cycle(port_req_t'(5'b01000), f);
      end
      drive_cycle('0, '0);
      wait_drained();
   endtask

   // north and south each send two 2-flit packets east at once
   task automatic contention();
      flit_t [num_ports-1:0] f;
      port_req_t v;
      int a;
      int b;
      int east;
      int first;
      int second;
      a = int'(PORT_NORTH);
      b = int'(PORT_SOUTH);
      east = int'(PORT_EAST);
      lat_check = 1'b0;
      head_src_q[east].delete();
      // nearer after the pointer wins, then the two take turns
      first = (rr_dist(ptr_model[east], a) < rr_dist(ptr_model[east], b)) ? a : b;
      second = (first == a) ? b : a;
      v = '0;
      v[a] = 1'b1;
      v[b] = 1'b1;
      for (int c = 0; c < 4; c++) begin
         f = '0;
         f[a] = make_flit(kind_of(c % 2, 2), 3, 1, a, seq);
         f[b] = make_flit(kind_of(c % 2, 2), 3, 0, b, seq + 1);
         seq += 2;
         drive_cycle(v, f);
      end
      drive_cycle('0, '0);
      wait_drained();
      assert (head_src_q[east].size() == 4) else begin
         errors++;
         $display("%0t: east output served %0d packets, 4 were sent",
                  $time, head_src_q[east].size());
      end
      for (int k = 0; k < head_src_q[east].size(); k++) begin
         assert (head_src_q[east][k] == ((k % 2 == 0) ? first : second)) else begin
            errors++;
            $display("Error at %0t: source of packet %0d on out_flit[%0d] expected %0d, got %0d",
                     $time, k, east, (k % 2 == 0) ? first : second, head_src_q[east][k]);
         end
      end
   endtask

   // all inputs, one packet of up to four flits each per round
   task automatic random_traffic();
      flit_t [num_ports-1:0] f;
      port_req_t v;
      int len [num_ports];
      int dx [num_ports];
      int dy [num_ports];
      lat_check = 1'b0;
      for (int r = 0; r < 30 && !timed_out; r++) begin
         for (int i = 0; i < num_ports; i++) begin
            // zero length keeps that input silent this round
            len[i] = int'($unsigned($random(seed)) % 5);
            dx[i] = int'($unsigned($random(seed)) % 4);
            dy[i] = int'($unsigned($random(seed)) % 4);
         end
         for (int c = 0; c < 4; c++) begin
            v = '0;
            f = '0;
            for (int i = 0; i < num_ports; i++) begin
               if (c < len[i]) begin
                  v[i] = 1'b1;
                  f[i] = make_flit(kind_of(c, len[i]), dx[i], dy[i], i, seq);
                  seq++;
               end
            end
            drive_cycle(v, f);
         end
         drive_cycle('0, '0);
         // drained fifos bound the next round to the buffer depth
         wait_drained();
      end
      assert (pending() == 0) else begin
         errors++;
         $display("%0t: %0d expected flits left in the model", $time, pending());
      end
   endtask

   initial begin
      clk = 1'b0;
      arst_n = 1'b0;
      in_valid = '0;
      in_flit = '0;
      seed = 83;
      errors = 0;
      checked = 0;
      seq = 0;
      timed_out = 1'b0;
      traffic_started = 1'b0;
      lat_check = 1'b1;
      for (int i = 0; i < num_ports; i++) begin
         ptr_model[i] = int'(PORT_LOCAL);
         open_src[i] = -1;
         cur_out[i] = int'(PORT_LOCAL);
      end
      repeat (3) @(posedge clk);
      #2;
      arst_n = 1'b1;
      // idle link check runs in the monitor
      repeat (4) @(posedge clk);
      single_sweep();
      if (!timed_out) long_packet();
      if (!timed_out) contention();
      if (!timed_out) random_traffic();
      $display("%0d flits checked, %0d errors, %0d timeouts", checked, errors, int'(timed_out));
      if (errors == 0 && !timed_out) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
